//--- build.f
common/vga_pkg.sv
common/scan_if.sv
vga_timing/vga_timing.sv
frame_buffer/wb_frame_buffer.sv
verilog/pixel_pipe.sv
verilog/vga_top.sv
verification/vga_chk.sv
verification/vga_tb.sv

//--- Makefile
# Verilator flow for the VGA display controller testbench

TOP = vga_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

# the run log decides the result, the pass line must be present on a line of its own
sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/vga_tb.sv
// testbench top with clock, reset, Wishbone tasks, xorshift stimulus, display scoreboard and watchdog
`timescale 1ns/1ps
`default_nettype none

module vga_tb;

	import vga_pkg::*;

	// a small visible area of 4x2 tiles keeps whole frames short
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 3;
	localparam int H_ACT = 32;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 2;
	localparam int V_ACT = 16;
	localparam int H_TOTAL = H_FRONT + H_SYNC + H_BACK + H_ACT;
	localparam int V_TOTAL = V_FRONT + V_SYNC + V_BACK + V_ACT;
	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int TILES_X = H_ACT >> TILE_SHIFT;
	localparam int TILES = TILES_X * (V_ACT >> TILE_SHIFT);
	localparam int IDX_W = $clog2(TILES);
	// three checked frames may each wait almost a frame for vs, plus reset and about 25 transfers
	localparam int LIMIT = 10 + 25 * 4 + 7 * FRAME;

	logic clk27;
	logic rst27;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_ADDR_W-1:0] wb_adr;
	logic [WB_DATA_W-1:0] wb_dat_w;
	wire logic [WB_DATA_W-1:0] wb_dat_r;
	wire logic wb_ack;
	wire logic [COLOR_W-1:0] vga_r;
	wire logic [COLOR_W-1:0] vga_g;
	wire logic [COLOR_W-1:0] vga_b;
	wire logic vga_hs;
	wire logic vga_vs;
	wire logic vga_blank;
	wire logic vga_clock;

	// expected tile contents and display mode
	rgb_t shadow [TILES];
	rgb_t exp_bg = '0;
	rgb_t exp_pix;
	logic exp_enable = 1'b0;
	logic [31:0] rng_state = 32'h778d1c85;
	logic [IDX_W-1:0] tile_idx;
	int bus_errs = 0;
	int pix_errs = 0;
	int tests_failed = 0;
	int req_cnt = 0;

	// display monitor state, owned by the monitor process
	int started_cnt;
	int done_cnt;
	int pix_cnt;
	int mon_x;
	int mon_y;
	logic checking;
	logic line_seen;
	logic hs_prev;
	logic vs_prev;

	vga_top #(
		.H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK), .H_ACT(H_ACT),
		.V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK), .V_ACT(V_ACT)
	) u_dut (.*);

	// bus and sync rules are watched inside the DUT with the same timing
	bind vga_top vga_chk #(
		.H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK), .H_ACT(H_ACT),
		.V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK), .V_ACT(V_ACT)
	) u_chk (
		.clk27(clk27), .rst27(rst27), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank(vga_blank)
	);

	initial begin
		clk27 = 1'b0;
		forever #50 clk27 = ~clk27;
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic int error_total();
		return bus_errs + pix_errs + u_dut.u_chk.fail_cnt;
	endfunction

	// one classic cycle, signals held until ack and dropped just after that edge
	task automatic bus_transfer(input logic we, input logic [WB_ADDR_W-1:0] addr,
			input logic [WB_DATA_W-1:0] wdata, output logic [WB_DATA_W-1:0] rdata);
		int wait_cnt;
		@(posedge clk27);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = addr;
		wb_dat_w = wdata;
		wait_cnt = 0;
		do begin
			@(posedge clk27);
			#1;
			wait_cnt++;
		end while (!wb_ack && wait_cnt < 8);
		if (!wb_ack) begin
			$display("no ack from the bus for address %h at time %0t", addr, $time);
			bus_errs++;
		end
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic check_read(input logic [WB_ADDR_W-1:0] addr, input logic [WB_DATA_W-1:0] exp);
		logic [WB_DATA_W-1:0] got;
		bus_transfer(1'b0, addr, '0, got);
		assert (got == exp) else begin
			$display("Mismatch at time %0t: address %h read %h, expected %h", $time, addr, got, exp);
			bus_errs++;
		end
	endtask

	// the monitor opens a checked frame at the next falling vs and closes it at the one after
	task automatic check_frame();
		req_cnt++;
		wait (done_cnt == req_cnt);
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (error_total() == errs_before) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			$display("test %0d %s: failed", num, name);
			tests_failed++;
		end
	endtask

	////////////////////
	// display monitor
	////////////////////

	// pins change on the rising edge, so they are read on the falling one
	always @(negedge clk27) begin
		if (rst27) begin
			started_cnt = 0;
			done_cnt = 0;
			pix_cnt = 0;
			mon_x = 0;
			mon_y = 0;
			checking = 1'b0;
			line_seen = 1'b0;
			hs_prev = 1'b1;
			vs_prev = 1'b1;
		end else begin
			if (vs_prev && !vga_vs) begin
				if (checking) begin
					assert (pix_cnt == H_ACT * V_ACT) else begin
						$display("Mismatch at time %0t: frame showed %0d visible pixels, expected %0d",
							$time, pix_cnt, H_ACT * V_ACT);
						pix_errs++;
					end
					done_cnt++;
				end
				checking = started_cnt != req_cnt;
				started_cnt = req_cnt;
				pix_cnt = 0;
				mon_y = 0;
			end
			// hs rises in the blanking before the pixels, so a seen line steps the row here
			if (!hs_prev && vga_hs) begin
				if (line_seen) begin
					mon_y++;
				end
				mon_x = 0;
				line_seen = 1'b0;
			end
			if (vga_blank) begin
				if (checking) begin
					tile_idx = IDX_W'((mon_y >> TILE_SHIFT) * TILES_X + (mon_x >> TILE_SHIFT));
					exp_pix = exp_enable ? shadow[tile_idx] : exp_bg;
					assert ({vga_r, vga_g, vga_b} == exp_pix) else begin
						$display("Mismatch at time %0t: pixel (%0d,%0d) is %h, expected %h",
							$time, mon_x, mon_y, {vga_r, vga_g, vga_b}, exp_pix);
						pix_errs++;
					end
					pix_cnt++;
				end
				mon_x++;
				line_seen = 1'b1;
			end
			hs_prev = vga_hs;
			vs_prev = vga_vs;
		end
	end

	// vga_clock is the inverted clk27 and is looked at in the middle of each clock phase
	always @(posedge clk27) begin
		#25;
		assert (vga_clock === 1'b0) else begin
			$display("Mismatch at time %0t: vga_clock is %b in the high phase, expected 0",
				$time, vga_clock);
			pix_errs++;
		end
		#50;
		assert (vga_clock === 1'b1) else begin
			$display("Mismatch at time %0t: vga_clock is %b in the low phase, expected 1",
				$time, vga_clock);
			pix_errs++;
		end
	end

	////////////////////
	// tests
	////////////////////

	initial begin
		int errs_before;
		logic [WB_DATA_W-1:0] wdata;
		logic [WB_DATA_W-1:0] rdata;
		rgb_t bg;
		rst27 = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (10) @(posedge clk27);
		#1;
		rst27 = 1'b0;

		// random words with the top nibble set too, only bits 11..0 are stored
		errs_before = error_total();
		for (int i = 0; i < TILES; i++) begin
			rng_state = next_random(rng_state);
			wdata = rng_state[WB_DATA_W-1:0];
			shadow[IDX_W'(i)] = wdata[11:0];
			bus_transfer(1'b1, WB_ADDR_W'(i), wdata, rdata);
		end
		for (int i = 0; i < TILES; i++) begin
			check_read(WB_ADDR_W'(i), {4'h0, shadow[IDX_W'(i)]});
		end
		report_test(1, "bus readback", errs_before);

		// reserved bits are written as ones and must come back as zero
		errs_before = error_total();
		rng_state = next_random(rng_state);
		bg = rng_state[11:0];
		bus_transfer(1'b1, CTRL_ADDR, {1'b1, 3'b111, bg}, rdata);
		check_read(CTRL_ADDR, {1'b1, 3'b000, bg});
		bus_transfer(1'b1, WB_ADDR_W'(TILES), 16'hffff, rdata);
		check_read(WB_ADDR_W'(TILES), '0);
		check_read(14'h2000, '0);
		check_read('0, {4'h0, shadow[0]});
		report_test(2, "control word", errs_before);

		errs_before = error_total();
		exp_enable = 1'b1;
		check_frame();
		report_test(3, "enabled display", errs_before);

		errs_before = error_total();
		rng_state = next_random(rng_state);
		bg = rng_state[11:0];
		bus_transfer(1'b1, CTRL_ADDR, {1'b0, 3'b000, bg}, rdata);
		exp_enable = 1'b0;
		exp_bg = bg;
		check_frame();
		bus_transfer(1'b1, CTRL_ADDR, {1'b1, 3'b000, bg}, rdata);
		exp_enable = 1'b1;
		check_frame();
		report_test(4, "disabled display", errs_before);

		if (u_dut.u_chk.fail_cnt == 0) begin
			$display("test 5 sync and blanking: passed");
		end else begin
			$display("test 5 sync and blanking: failed");
			tests_failed++;
		end

		$display("tests 5, failed %0d, bus errors %0d, pixel errors %0d, assertion failures %0d",
			tests_failed, bus_errs, pix_errs, u_dut.u_chk.fail_cnt);
		if (tests_failed == 0 && error_total() == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// watchdog on the clock, sized from the frames and bus traffic above
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk27);
			cycles++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/vga_chk.sv
// bound assertions for the Wishbone handshake, sync pulse widths and blanking
`timescale 1ns/1ps
`default_nettype none

module vga_chk #(
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int H_ACT = 640,
	parameter int V_FRONT = 11,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 31,
	parameter int V_ACT = 480
) (
	input wire logic clk27,
	input wire logic rst27,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_ack,
	input wire logic [vga_pkg::COLOR_W-1:0] vga_r,
	input wire logic [vga_pkg::COLOR_W-1:0] vga_g,
	input wire logic [vga_pkg::COLOR_W-1:0] vga_b,
	input wire logic vga_hs,
	input wire logic vga_vs,
	input wire logic vga_blank
);

	import vga_pkg::*;

	localparam int H_TOTAL = H_FRONT + H_SYNC + H_BACK + H_ACT;

	// the testbench reads this count at the end of the run
	int fail_cnt = 0;
	int hs_low_len;
	int vs_low_len;
	int blank_len;
	int since_hs_fall;
	logic seen_hs_fall;
	logic hs_q;

	////////////////////
	// pulse counters
	////////////////////

	// each counter holds the run length seen up to the edge where its pulse ends
	always_ff @(posedge clk27) begin
		if (rst27) begin
			hs_low_len <= 0;
			vs_low_len <= 0;
			blank_len <= 0;
			since_hs_fall <= 0;
			seen_hs_fall <= 1'b0;
			hs_q <= 1'b1;
		end else begin
			hs_low_len <= vga_hs ? 0 : hs_low_len + 1;
			vs_low_len <= vga_vs ? 0 : vs_low_len + 1;
			blank_len <= vga_blank ? blank_len + 1 : 0;
			if (hs_q && !vga_hs) begin
				since_hs_fall <= 1;
				seen_hs_fall <= 1'b1;
			end else begin
				since_hs_fall <= since_hs_fall + 1;
			end
			hs_q <= vga_hs;
		end
	end

	////////////////////
	// bus rules
	////////////////////

	ack_after_req: assert property (@(posedge clk27) disable iff (rst27)
		wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
		else begin $error("ack without a request on the cycle before"); fail_cnt = fail_cnt + 1; end

	ack_single: assert property (@(posedge clk27) disable iff (rst27) wb_ack |=> !wb_ack)
		else begin $error("ack held longer than one cycle"); fail_cnt = fail_cnt + 1; end

	////////////////////
	// sync and blanking
	////////////////////

	hs_width: assert property (@(posedge clk27) disable iff (rst27)
		$rose(vga_hs) |-> hs_low_len == H_SYNC)
		else begin $error("hs low for the wrong number of cycles"); fail_cnt = fail_cnt + 1; end

	hs_period: assert property (@(posedge clk27) disable iff (rst27)
		($fell(vga_hs) && seen_hs_fall) |-> since_hs_fall == H_TOTAL)
		else begin $error("hs falling edges not one line apart"); fail_cnt = fail_cnt + 1; end

	// vs low for V_SYNC whole lines
	vs_width: assert property (@(posedge clk27) disable iff (rst27)
		$rose(vga_vs) |-> vs_low_len == V_SYNC * H_TOTAL)
		else begin $error("vs low for the wrong number of lines"); fail_cnt = fail_cnt + 1; end

	black_in_blank: assert property (@(posedge clk27) disable iff (rst27)
		!vga_blank |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else begin $error("colour pins driven while blanked"); fail_cnt = fail_cnt + 1; end

	blank_width: assert property (@(posedge clk27) disable iff (rst27)
		$fell(vga_blank) |-> blank_len == H_ACT)
		else begin $error("visible line has the wrong length"); fail_cnt = fail_cnt + 1; end

endmodule

`default_nettype wire

//--- verilog/vga_top.sv
// display controller top level with the timing generator, frame buffer and pixel pipeline
`timescale 1ns/1ps
`default_nettype none

module vga_top #(
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int H_ACT = 640,
	parameter int V_FRONT = 11,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 31,
	parameter int V_ACT = 480
) (
	input wire logic clk27,
	input wire logic rst27,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [vga_pkg::WB_ADDR_W-1:0] wb_adr,
	input wire logic [vga_pkg::WB_DATA_W-1:0] wb_dat_w,
	output logic [vga_pkg::WB_DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	output logic [vga_pkg::COLOR_W-1:0] vga_r,
	output logic [vga_pkg::COLOR_W-1:0] vga_g,
	output logic [vga_pkg::COLOR_W-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank,
	output logic vga_clock
);

	import vga_pkg::*;

	scan_if scan ();

	logic [WB_ADDR_W-1:0] rd_addr;
	rgb_t rd_data;
	ctrl_t ctrl;

	// the DAC latches on the falling edge of the pixel clock
	assign vga_clock = ~clk27;

	////////////////////
	// instances
	////////////////////

	vga_timing #(
		.H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK), .H_ACT(H_ACT),
		.V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK), .V_ACT(V_ACT)
	) u_timing (
		.clk27(clk27), .rst27(rst27), .scan(scan.source)
	);

	// tile RAM and control word, the bus sees one cycle to ack
	wb_frame_buffer #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_frame_buffer (
		.clk27(clk27), .rst27(rst27),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.rd_addr(rd_addr), .rd_data(rd_data), .ctrl(ctrl)
	);

	// two cycles from scan position to pins
	pixel_pipe #(.H_ACT(H_ACT)) u_pixel_pipe (
		.clk27(clk27), .rst27(rst27), .scan(scan.sink),
		.rd_addr(rd_addr), .rd_data(rd_data), .ctrl(ctrl),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank(vga_blank)
	);

endmodule

`default_nettype wire

//--- verilog/pixel_pipe.sv
// tile address generation, colour select and the registered VGA pins
`timescale 1ns/1ps
`default_nettype none

module pixel_pipe #(
	parameter int H_ACT = 640
) (
	input wire logic clk27,
	input wire logic rst27,
	scan_if.sink scan,
	output logic [vga_pkg::WB_ADDR_W-1:0] rd_addr,
	input wire vga_pkg::rgb_t rd_data,
	input wire vga_pkg::ctrl_t ctrl,
	output logic [vga_pkg::COLOR_W-1:0] vga_r,
	output logic [vga_pkg::COLOR_W-1:0] vga_g,
	output logic [vga_pkg::COLOR_W-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank
);

	import vga_pkg::*;

	// number of tiles across one visible line
	localparam logic [WB_ADDR_W-1:0] TILES_X = WB_ADDR_W'(H_ACT >> TILE_SHIFT);

	logic [WB_ADDR_W-1:0] tile_col;
	logic [WB_ADDR_W-1:0] tile_row;
	logic active_d;
	logic hs_d;
	logic vs_d;
	rgb_t pix;

	////////////////////
	// stage one
	////////////////////

	// row major tile address, the RAM registers the word on the next edge
	assign tile_col = WB_ADDR_W'(scan.x >> TILE_SHIFT);
	assign tile_row = WB_ADDR_W'(scan.y >> TILE_SHIFT);
	assign rd_addr = tile_row * TILES_X + tile_col;

	// sync and active wait one cycle alongside the RAM read
	always_ff @(posedge clk27) begin
		if (rst27) begin
			active_d <= 1'b0;
			hs_d <= 1'b1;
			vs_d <= 1'b1;
		end else begin
			active_d <= scan.active;
			hs_d <= scan.hs;
			vs_d <= scan.vs;
		end
	end

	////////////////////
	// stage two
	////////////////////

	// tile colour when enabled, background otherwise, black in blanking
	always_comb begin
		if (!active_d) begin
			pix = '0;
		end else if (ctrl.enable) begin
			pix = rd_data;
		end else begin
			pix = ctrl.bg;
		end
	end

	// pins change together, two cycles after the scan position
	always_ff @(posedge clk27) begin
		if (rst27) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_blank <= 1'b0;
		end else begin
			vga_r <= pix.r;
			vga_g <= pix.g;
			vga_b <= pix.b;
			vga_hs <= hs_d;
			vga_vs <= vs_d;
			vga_blank <= active_d;
		end
	end

endmodule

`default_nettype wire

//--- frame_buffer/wb_frame_buffer.sv
// Wishbone classic slave with the tile RAM, the control register and the display read port
`timescale 1ns/1ps
`default_nettype none

module wb_frame_buffer #(
	parameter int H_ACT = 640,
	parameter int V_ACT = 480
) (
	input wire logic clk27,
	input wire logic rst27,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [vga_pkg::WB_ADDR_W-1:0] wb_adr,
	input wire logic [vga_pkg::WB_DATA_W-1:0] wb_dat_w,
	output logic [vga_pkg::WB_DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	input wire logic [vga_pkg::WB_ADDR_W-1:0] rd_addr,
	output vga_pkg::rgb_t rd_data,
	output vga_pkg::ctrl_t ctrl
);

	import vga_pkg::*;

	// one word per tile of the visible area
	localparam int DEPTH = (H_ACT >> TILE_SHIFT) * (V_ACT >> TILE_SHIFT);
	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [WB_ADDR_W-1:0] DEPTH_A = WB_ADDR_W'(DEPTH);
	localparam int RGB_W = $bits(rgb_t);

	rgb_t mem [DEPTH];

	logic req;
	logic in_range;
	logic is_ctrl;
	logic [IDX_W-1:0] a_idx;
	logic [IDX_W-1:0] b_idx;

	////////////////////
	// bus decode
	////////////////////

	// a new request is only taken when no ack is out, so each ack lasts one cycle
	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign in_range = wb_adr < DEPTH_A;
	assign is_ctrl = wb_adr == CTRL_ADDR;
	assign a_idx = wb_adr[IDX_W-1:0];
	assign b_idx = rd_addr[IDX_W-1:0];

	// ack and control word are the only state that reset clears
	always_ff @(posedge clk27) begin
		if (rst27) begin
			wb_ack <= 1'b0;
			ctrl <= '0;
		end else begin
			wb_ack <= req;
			if (req && wb_we && is_ctrl) begin
				ctrl.enable <= wb_dat_w[WB_DATA_W-1];
				ctrl.rsvd <= '0;
				ctrl.bg <= wb_dat_w[RGB_W-1:0];
			end
		end
	end

	////////////////////
	// port A, host side
	////////////////////

	// the write lands on the same edge that raises ack
	// read data is captured on that edge and holds while ack is high
	always_ff @(posedge clk27) begin
		if (req) begin
			if (wb_we && in_range) begin
				mem[a_idx] <= wb_dat_w[RGB_W-1:0];
			end
			if (in_range) begin
				wb_dat_r <= {{(WB_DATA_W-RGB_W){1'b0}}, mem[a_idx]};
			end else if (is_ctrl) begin
				wb_dat_r <= ctrl;
			end else begin
				// holes between the tiles and the control word read as zero
				wb_dat_r <= '0;
			end
		end
	end

	////////////////////
	// port B, display side
	////////////////////

	// registered read, the pipeline counts this as its first stage
	always_ff @(posedge clk27) begin
		rd_data <= mem[b_idx];
	end

endmodule

`default_nettype wire

//--- vga_timing/vga_timing.sv
// horizontal and vertical counters with registered sync, active flag and pixel coordinates
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int H_ACT = 640,
	parameter int V_FRONT = 11,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 31,
	parameter int V_ACT = 480
) (
	input wire logic clk27,
	input wire logic rst27,
	scan_if.source scan
);

	import vga_pkg::*;

	////////////////////
	// derived timing
	////////////////////

	// the blanking region is the three porch and sync phases put together
	localparam int H_BLANK = H_FRONT + H_SYNC + H_BACK;
	localparam int H_TOTAL = H_BLANK + H_ACT;
	localparam int V_BLANK = V_FRONT + V_SYNC + V_BACK;
	localparam int V_TOTAL = V_BLANK + V_ACT;

	// compare points sized to the counters
	localparam logic [COORD_W-1:0] H_SYNC_BEG = COORD_W'(H_FRONT);
	localparam logic [COORD_W-1:0] H_SYNC_END = COORD_W'(H_FRONT + H_SYNC);
	localparam logic [COORD_W-1:0] H_ACT_BEG = COORD_W'(H_BLANK);
	localparam logic [COORD_W-1:0] H_LAST = COORD_W'(H_TOTAL - 1);
	localparam logic [COORD_W-1:0] V_SYNC_BEG = COORD_W'(V_FRONT);
	localparam logic [COORD_W-1:0] V_SYNC_END = COORD_W'(V_FRONT + V_SYNC);
	localparam logic [COORD_W-1:0] V_ACT_BEG = COORD_W'(V_BLANK);
	localparam logic [COORD_W-1:0] V_LAST = COORD_W'(V_TOTAL - 1);

	logic [COORD_W-1:0] h_cnt;
	logic [COORD_W-1:0] v_cnt;
	logic h_in_sync;
	logic v_in_sync;
	logic visible;

	////////////////////
	// counters
	////////////////////

	// a line is exactly H_TOTAL cycles and a frame exactly V_TOTAL lines
	always_ff @(posedge clk27) begin
		if (rst27) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			// the line counter steps as the pixel counter wraps
			if (v_cnt == V_LAST) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	////////////////////
	// phase decode
	////////////////////

	// counter order is front porch, sync, back porch, then active
	always_comb begin
		h_in_sync = (h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END);
		// v_cnt only moves at a wrap, so vs changes at a line start
		v_in_sync = (v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END);
		visible = (h_cnt >= H_ACT_BEG) && (v_cnt >= V_ACT_BEG);
	end

	// all outputs come from the same counter pair so they stay in step
	always_ff @(posedge clk27) begin
		if (rst27) begin
			scan.hs <= 1'b1;
			scan.vs <= 1'b1;
			scan.active <= 1'b0;
			scan.x <= '0;
			scan.y <= '0;
		end else begin
			scan.hs <= ~h_in_sync;
			scan.vs <= ~v_in_sync;
			scan.active <= visible;
			// coordinates are parked at zero in the blanking region
			scan.x <= visible ? h_cnt - H_ACT_BEG : '0;
			scan.y <= visible ? v_cnt - V_ACT_BEG : '0;
		end
	end

endmodule

`default_nettype wire

//--- common/scan_if.sv
// scan position and raw sync from the timing generator to the pixel pipeline
`timescale 1ns/1ps
`default_nettype none

interface scan_if;

	import vga_pkg::*;

	// pixel coordinates inside the visible area, zero outside it
	logic [COORD_W-1:0] x;
	logic [COORD_W-1:0] y;

	// high while the scan position is inside the visible area
	logic active;

	// raw active-low sync, before the pipeline delay
	logic hs;
	logic vs;

	// the timing generator owns every signal
	modport source (
		output x, y, active, hs, vs
	);

	// the pixel pipeline only looks
	modport sink (
		input x, y, active, hs, vs
	);

endinterface

`default_nettype wire

//--- common/vga_pkg.sv
// shared widths, colour and control word types, and the control word address
`default_nettype none

package vga_pkg;

	////////////////////
	// widths
	////////////////////

	// each colour channel drives a 4-bit resistor DAC per pin group
	localparam int COLOR_W = 4;

	// horizontal and vertical counters share one width, enough for an 800 cycle line
	localparam int COORD_W = 10;

	// tiles are 8x8 pixels, so a coordinate shifted by 3 gives the tile column or row
	localparam int TILE_SHIFT = 3;

	// host bus word address and data widths
	localparam int WB_ADDR_W = 14;
	localparam int WB_DATA_W = 16;

	// the control word sits at the very top of the address space
	localparam logic [WB_ADDR_W-1:0] CTRL_ADDR = '1;

	////////////////////
	// types
	////////////////////

	// one pixel colour with red in the upper bits, 12 bits in total
	typedef struct packed {
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
	} rgb_t;

	// control word layout, the reserved field always reads as zero
	typedef struct packed {
		logic enable;
		logic [2:0] rsvd;
		rgb_t bg;
	} ctrl_t;

endpackage

`default_nettype wire
